// File: Bender.yml
package:
  name: fifo_sys

sources:
  - fifo_pkg.sv
  - fifo_level_ctrl.sv
  - fifo_write_router.sv
  - fifo_mem_lane.sv
  - fifo_read_gather.sv
  - fifo_sys_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_fifo_sys.sv

// File: fifo_level_ctrl.sv
`timescale 1ns/100ps

module fifo_level_ctrl #(
   parameter int ADDR_W = 6
) (
   input  logic            clk_i,
   input  logic            reset_i,

   // request strobes
   input  logic            w_en_i,
   input  logic            r_en_i,

   // accepted strobes
   output logic            w_acc_o,
   output logic            r_acc_o,

   // registered flags
   output logic            w_full_o,
   output logic            r_empty_o,

   // fill level in narrow words
   output logic [ADDR_W:0] level_o
);

   import fifo_pkg::*;

   localparam int LEVEL_W = ADDR_W + 1;

   // depth in narrow words
   localparam logic [LEVEL_W-1:0] DEPTH = LEVEL_W'(1) << ADDR_W;

   // a write adds one narrow word, a read takes a whole wide word
   localparam logic [LEVEL_W-1:0] W_INCR = LEVEL_W'(1);
   localparam logic [LEVEL_W-1:0] R_DECR = LEVEL_W'(RATIO);

   logic [LEVEL_W-1:0] level_nxt;
   logic               r_empty_nxt;
   logic               w_full_nxt;

   // requests against the registered flags
   assign w_acc_o = w_en_i & ~w_full_o;
   assign r_acc_o = r_en_i & ~r_empty_o;

   // next level from the accepted strobes
   always_comb begin
      level_nxt = level_o;
      if (w_acc_o && !r_acc_o) begin
         level_nxt = level_o + W_INCR;
      end else if (w_acc_o && r_acc_o) begin
         level_nxt = level_o + W_INCR - R_DECR;
      end else if (r_acc_o) begin
         level_nxt = level_o - R_DECR;
      end
   end

   // empty while less than one wide word is stored
   assign r_empty_nxt = level_nxt < R_DECR;

   // full once no room is left for another narrow word
   assign w_full_nxt = level_nxt > (DEPTH - W_INCR);

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         level_o <= '0;
      end else begin
         level_o <= level_nxt;
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         r_empty_o <= 1'b1;
      end else begin
         r_empty_o <= r_empty_nxt;
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         w_full_o <= 1'b0;
      end else begin
         w_full_o <= w_full_nxt;
      end
   end

endmodule

// File: fifo_mem_lane.sv
`timescale 1ns/100ps

module fifo_mem_lane #(
   parameter int ADDR_W = 6
) (
   input  logic                                   clk_i,

   // write port
   input  logic                                   we_i,
   input  logic [ADDR_W-fifo_pkg::LANE_SEL_W-1:0] w_row_i,
   input  logic [fifo_pkg::NARROW_W-1:0]          w_data_i,

   // read port
   input  logic [ADDR_W-fifo_pkg::LANE_SEL_W-1:0] r_row_i,
   output logic [fifo_pkg::NARROW_W-1:0]          r_data_o
);

   import fifo_pkg::*;

   localparam int ROW_W = ADDR_W - LANE_SEL_W;
   localparam int ROWS = 2 ** ROW_W;

   logic [NARROW_W-1:0] mem [ROWS];

   always_ff @(posedge clk_i) begin
      if (we_i) begin
         mem[w_row_i] <= w_data_i;
      end
   end

   // row read without a register, the gather samples it
   assign r_data_o = mem[r_row_i];

endmodule

// File: fifo_pkg.sv
package fifo_pkg;

   // narrow write side and wide read side
   localparam int NARROW_W = 8;
   localparam int WIDE_W = 32;

   // narrow words per wide word, one memory lane each
   localparam int RATIO = WIDE_W / NARROW_W;

   // low write pointer bits that pick the lane
   localparam int LANE_SEL_W = $clog2(RATIO);

   // wide read word, seen whole or as lane bytes
   // lane[0] holds the oldest of the four writes
   typedef union packed {
      logic [WIDE_W-1:0]              word;
      logic [RATIO-1:0][NARROW_W-1:0] lane;
   } wide_word_u;

endpackage

// File: fifo_read_gather.sv
`timescale 1ns/100ps

module fifo_read_gather #(
   parameter int ADDR_W = 6
) (
   input  logic                                   clk_i,
   input  logic                                   reset_i,

   // accepted read
   input  logic                                   r_acc_i,

   // lane bytes, lane 0 in the low bits
   input  logic [fifo_pkg::WIDE_W-1:0]            lane_rdata_i,

   // shared read row
   output logic [ADDR_W-fifo_pkg::LANE_SEL_W-1:0] r_row_o,

   // registered wide word and its pulse
   output fifo_pkg::wide_word_u                   r_data_o,
   output logic                                   r_valid_o
);

   import fifo_pkg::*;

   localparam int ROW_W = ADDR_W - LANE_SEL_W;

   logic [ROW_W-1:0] r_row;

   // read row pointer
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         r_row <= '0;
      end else if (r_acc_i) begin
         r_row <= r_row + ROW_W'(1);
      end
   end

   assign r_row_o = r_row;

   // capture all lanes of the current row
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         r_data_o <= '0;
      end else if (r_acc_i) begin
         for (int i = 0; i < RATIO; i++) begin
            r_data_o.lane[i] <= lane_rdata_i[i*NARROW_W +: NARROW_W];
         end
      end
   end

   // one cycle per accepted read
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         r_valid_o <= 1'b0;
      end else begin
         r_valid_o <= r_acc_i;
      end
   end

endmodule

// File: fifo_sys_top.sv
`timescale 1ns/100ps

module fifo_sys_top #(
   parameter int ADDR_W = 6
) (
   input  logic                          clk_i,
   input  logic                          reset_i,

   // write port
   input  logic                          w_en_i,
   input  logic [fifo_pkg::NARROW_W-1:0] w_data_i,
   output logic                          w_full_o,

   // read port
   input  logic                          r_en_i,
   output logic [fifo_pkg::WIDE_W-1:0]   r_data_o,
   output logic                          r_valid_o,
   output logic                          r_empty_o,

   // fill level in narrow words
   output logic [ADDR_W:0]               level_o
);

   import fifo_pkg::*;

   localparam int ROW_W = ADDR_W - LANE_SEL_W;

   logic                w_acc;
   logic                r_acc;
   logic [RATIO-1:0]    lane_we;
   logic [ROW_W-1:0]    w_row;
   logic [NARROW_W-1:0] lane_wdata;
   logic [ROW_W-1:0]    r_row;
   logic [WIDE_W-1:0]   lane_rdata;
   wide_word_u          r_word;

   fifo_level_ctrl #(
      .ADDR_W(ADDR_W)
   ) level_ctrl0 (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .w_en_i   (w_en_i),
      .r_en_i   (r_en_i),
      .w_acc_o  (w_acc),
      .r_acc_o  (r_acc),
      .w_full_o (w_full_o),
      .r_empty_o(r_empty_o),
      .level_o  (level_o)
   );

   fifo_write_router #(
      .ADDR_W(ADDR_W)
   ) router0 (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .w_acc_i     (w_acc),
      .w_data_i    (w_data_i),
      .lane_we_o   (lane_we),
      .w_row_o     (w_row),
      .lane_wdata_o(lane_wdata)
   );

   // one byte-wide lane per narrow word of the wide word
   for (genvar i = 0; i < RATIO; i++) begin : g_lane
      fifo_mem_lane #(
         .ADDR_W(ADDR_W)
      ) lane0 (
         .clk_i   (clk_i),
         .we_i    (lane_we[i]),
         .w_row_i (w_row),
         .w_data_i(lane_wdata),
         .r_row_i (r_row),
         .r_data_o(lane_rdata[i*NARROW_W +: NARROW_W])
      );
   end

   fifo_read_gather #(
      .ADDR_W(ADDR_W)
   ) gather0 (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .r_acc_i     (r_acc),
      .lane_rdata_i(lane_rdata),
      .r_row_o     (r_row),
      .r_data_o    (r_word),
      .r_valid_o   (r_valid_o)
   );

   assign r_data_o = r_word.word;

endmodule

// File: fifo_write_router.sv
`timescale 1ns/100ps

module fifo_write_router #(
   parameter int ADDR_W = 6
) (
   input  logic                                   clk_i,
   input  logic                                   reset_i,

   // accepted write and its byte
   input  logic                                   w_acc_i,
   input  logic [fifo_pkg::NARROW_W-1:0]          w_data_i,

   // lane write side
   output logic [fifo_pkg::RATIO-1:0]             lane_we_o,
   output logic [ADDR_W-fifo_pkg::LANE_SEL_W-1:0] w_row_o,
   output logic [fifo_pkg::NARROW_W-1:0]          lane_wdata_o
);

   import fifo_pkg::*;

   localparam int ROW_W = ADDR_W - LANE_SEL_W;

   // narrow write pointer, wraps at the depth
   logic [ADDR_W-1:0]     w_ptr;
   logic [LANE_SEL_W-1:0] lane_sel;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         w_ptr <= '0;
      end else if (w_acc_i) begin
         w_ptr <= w_ptr + ADDR_W'(1);
      end
   end

   // low bits pick the lane, high bits the row
   assign lane_sel = w_ptr[LANE_SEL_W-1:0];
   assign w_row_o  = w_ptr[LANE_SEL_W +: ROW_W];

   // one-hot lane enable, only on an accepted write
   always_comb begin
      lane_we_o           = '0;
      lane_we_o[lane_sel] = w_acc_i;
   end

   // same byte to every lane, the enable decides
   assign lane_wdata_o = w_data_i;

endmodule

// File: tb.f
+incdir+.
fifo_pkg.sv
fifo_level_ctrl.sv
fifo_write_router.sv
fifo_mem_lane.sv
fifo_read_gather.sv
fifo_sys_top.sv
tb_fifo_sys.sv

// File: tb_fifo_ref.svh
// next wide word from the model queue with the oldest byte in lane 0
function automatic wide_word_u ref_wide_word();
   wide_word_u word;
   word = '0;
   for (int i = 0; i < RATIO; i++) begin
      word.lane[i] = byte_q.pop_front();
   end
   return word;
endfunction

task automatic check_word(
   input string      name,
   input wide_word_u exp,
   input wide_word_u act
);
   if (act.word !== exp.word) begin
      value_errs++;
      $display("ERROR %s: expected 0x%h, actual 0x%h at %0t",
               name, exp.word, act.word, $time);
   end
endtask

task automatic check_flag(
   input string name,
   input logic  exp,
   input logic  act
);
   if (act !== exp) begin
      value_errs++;
      $display("ERROR %s: expected 0x%h, actual 0x%h at %0t",
               name, exp, act, $time);
   end
endtask

task automatic check_level(
   input string              name,
   input logic [LEVEL_W-1:0] exp,
   input logic [LEVEL_W-1:0] act
);
   if (act !== exp) begin
      value_errs++;
      $display("ERROR %s: expected 0x%h, actual 0x%h at %0t",
               name, exp, act, $time);
   end
endtask

// File: tb_fifo_sys.sv
`timescale 1ns/100ps

module tb_fifo_sys;

   import fifo_pkg::*;

   localparam int ADDR_W = 6;
   localparam int LEVEL_W = ADDR_W + 1;
   localparam int DEPTH = 2 ** ADDR_W;

   // random phase plus reset and directed phases with margin
   localparam int RAND_CYCLES = 1600;
   localparam int STIM_CYCLES = RAND_CYCLES + 400;
   localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES;

   logic                clk;
   logic                reset;
   logic                w_en;
   logic [NARROW_W-1:0] w_data;
   logic                r_en;
   logic [WIDE_W-1:0]   r_data;
   logic                r_valid;
   logic                r_empty;
   logic                w_full;
   logic [LEVEL_W-1:0]  level;

   // model state
   logic [NARROW_W-1:0] byte_q[$];
   logic [LEVEL_W-1:0]  exp_level;
   logic                exp_empty;
   logic                exp_full;
   logic                exp_valid;
   wide_word_u          exp_word;
   wide_word_u          got_word;

   int value_errs = 0;
   int other_errs = 0;
   int cycles = 0;

   `include "tb_fifo_ref.svh"

   fifo_sys_top #(
      .ADDR_W(ADDR_W)
   ) dut (
      .clk_i    (clk),
      .reset_i  (reset),
      .w_en_i   (w_en),
      .w_data_i (w_data),
      .w_full_o (w_full),
      .r_en_i   (r_en),
      .r_data_o (r_data),
      .r_valid_o(r_valid),
      .r_empty_o(r_empty),
      .level_o  (level)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #20 clk = ~clk;
      end
   end

   task automatic drive_cycle(
      input logic                we,
      input logic [NARROW_W-1:0] wd,
      input logic                re
   );
      w_en = we;
      w_data = wd;
      r_en = re;
      @(posedge clk);
      #5;
   endtask

   function automatic logic [NARROW_W-1:0] rand_byte();
      return NARROW_W'($urandom);
   endfunction

   // high with a probability of eighths/8
   function automatic logic chance(input int eighths);
      return ($urandom % 8) < eighths;
   endfunction

   task automatic finish_run();
      $display("value errors: %0d, other errors: %0d", value_errs, other_errs);
      if (value_errs == 0 && other_errs == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   endtask

   // check outputs before the edge and then advance the model by it
   always @(posedge clk) begin : model_step
      logic w_acc;
      logic r_acc;
      int   lvl_next;
      if (reset) begin
         byte_q.delete();
         exp_level = '0;
         exp_empty = 1'b1;
         exp_full = 1'b0;
         exp_valid = 1'b0;
         exp_word = '0;
      end else begin
         got_word.word = r_data;
         check_level("level_o", exp_level, level);
         check_flag("r_empty_o", exp_empty, r_empty);
         check_flag("w_full_o", exp_full, w_full);
         check_flag("r_valid_o", exp_valid, r_valid);
         if (exp_valid) begin
            check_word("r_data_o", exp_word, got_word);
         end
         // acceptance from the flags in force at this edge
         w_acc = w_en && !exp_full;
         r_acc = r_en && !exp_empty;
         exp_valid = r_acc;
         if (r_acc) begin
            exp_word = ref_wide_word();
         end
         if (w_acc) begin
            byte_q.push_back(w_data);
         end
         lvl_next = int'(exp_level) + (w_acc ? 1 : 0) - (r_acc ? RATIO : 0);
         exp_level = LEVEL_W'(lvl_next);
         exp_empty = lvl_next < RATIO;
         exp_full = lvl_next > DEPTH - 1;
      end
   end

   initial begin
      while (cycles < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      other_errs++;
      $display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
      finish_run();
   end

   initial begin
      int n_acc;
      void'($urandom(32'h4851757a));
      reset = 1'b1;
      w_en = 1'b0;
      w_data = '0;
      r_en = 1'b0;
      repeat (10) @(posedge clk);
      #5;
      reset = 1'b0;

      // idle after reset
      repeat (4) drive_cycle(1'b0, '0, 1'b0);

      // one wide word with the first byte in lane 0
      drive_cycle(1'b1, 8'h11, 1'b0);
      drive_cycle(1'b1, 8'h22, 1'b0);
      drive_cycle(1'b1, 8'h33, 1'b0);
      drive_cycle(1'b1, 8'h44, 1'b0);
      while (r_empty) drive_cycle(1'b0, '0, 1'b0);
      drive_cycle(1'b0, '0, 1'b1);
      repeat (3) drive_cycle(1'b0, '0, 1'b0);

      // fill up and then write against full
      n_acc = 0;
      while (!w_full) begin
         drive_cycle(1'b1, rand_byte(), 1'b0);
         n_acc++;
      end
      if (n_acc != DEPTH) begin
         other_errs++;
         $display("full after %0d writes instead of %0d", n_acc, DEPTH);
      end
      repeat (4) drive_cycle(1'b1, rand_byte(), 1'b0);
      drive_cycle(1'b0, '0, 1'b0);

      // drain and then read against empty
      n_acc = 0;
      while (!r_empty) begin
         drive_cycle(1'b0, '0, 1'b1);
         n_acc++;
      end
      if (n_acc != DEPTH / RATIO) begin
         other_errs++;
         $display("empty after %0d reads instead of %0d", n_acc, DEPTH / RATIO);
      end
      repeat (2) drive_cycle(1'b0, '0, 1'b1);
      repeat (2) drive_cycle(1'b0, '0, 1'b0);

      // write heavy random traffic followed by read heavy traffic
      repeat (RAND_CYCLES / 2) drive_cycle(chance(7), rand_byte(), chance(1));
      repeat (RAND_CYCLES / 2) drive_cycle(chance(4), rand_byte(), chance(2));
      repeat (4) drive_cycle(1'b0, '0, 1'b0);

      finish_run();
   end

endmodule
